// ==== vlog.f ====
+incdir+verification
src/mmu_arch_pkg.sv
src/mmu_tlb_pkg.sv
src/tlb_array.sv
src/addr_translate.sv
src/tlb_maint_fsm.sv
src/tlb_index_counter.sv
src/mmu_top.sv
verification/mmu_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Compile and run the MMU testbench with Verilator; exit status is the result.
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal -f vlog.f --top-module mmu_tb -o mmu_sim
./obj_dir/mmu_sim

// ==== verification/mmu_model.svh ====
`ifndef MMU_MODEL_SVH
`define MMU_MODEL_SVH

// shadow TLB, updated in step with the maintenance stimulus
logic        m_e    [ENTRIES];
logic        m_g    [ENTRIES];
logic        m_huge [ENTRIES];
logic [18:0] m_vppn [ENTRIES];
logic [9:0]  m_asid [ENTRIES];
logic [19:0] m_ppn  [ENTRIES][2];  // [0] even page, [1] odd page
logic [1:0]  m_plv  [ENTRIES][2];
logic [1:0]  m_mat  [ENTRIES][2];
logic        m_v    [ENTRIES][2];
logic        m_d    [ENTRIES][2];
int          fill_ptr;

function automatic void shadow_clear();
    for (int i = 0; i < ENTRIES; i++) begin
        m_e[i]    = 1'b0;
        m_g[i]    = 1'b0;
        m_huge[i] = 1'b0;
        m_vppn[i] = '0;
        m_asid[i] = '0;
    end
    fill_ptr = 0;
endfunction

// copies the entry fields currently driven into the DUT
function automatic void shadow_store(input int idx);
    m_e[idx]      = entry_e_i;
    m_g[idx]      = entry_g_i;
    m_huge[idx]   = entry_huge_i;
    m_vppn[idx]   = entry_vppn_i;
    m_asid[idx]   = entry_asid_i;
    m_ppn[idx][0] = entry_ppn0_i;
    m_plv[idx][0] = entry_plv0_i;
    m_mat[idx][0] = entry_mat0_i;
    m_v[idx][0]   = entry_v0_i;
    m_d[idx][0]   = entry_d0_i;
    m_ppn[idx][1] = entry_ppn1_i;
    m_plv[idx][1] = entry_plv1_i;
    m_mat[idx][1] = entry_mat1_i;
    m_v[idx][1]   = entry_v1_i;
    m_d[idx][1]   = entry_d1_i;
endfunction

function automatic void shadow_invalidate(input logic asid_only, input logic [9:0] asid);
    for (int i = 0; i < ENTRIES; i++) begin
        if (!asid_only || (!m_g[i] && m_asid[i] == asid)) begin
            m_e[i] = 1'b0;
        end
    end
endfunction

// window matches on vseg when the current plv is enabled in it
function automatic logic window_hit(input logic [31:0] dmw, input logic [31:0] va,
                                    input logic [1:0] plv);
    return dmw[31:29] == va[31:29] && ((plv == 2'd0 && dmw[0]) || (plv == 2'd3 && dmw[3]));
endfunction

function automatic void expect_translation(
    input  logic [31:0] va,
    input  logic [1:0]  acc,
    input  logic [31:0] crmd,
    input  logic [31:0] dmw0,
    input  logic [31:0] dmw1,
    input  logic [9:0]  asid,
    output logic [31:0] pa,
    output logic [1:0]  mat,
    output logic [5:0]  ecode
);
    logic [1:0] plv;
    logic       odd;
    int         k;
    plv   = crmd[1:0];
    pa    = va;
    mat   = (acc == mmu_arch_pkg::ACC_FETCH) ? crmd[6:5] : crmd[8:7];  // datf or datm
    ecode = mmu_arch_pkg::ECODE_NONE;
    k     = -1;
    if (crmd[3]) begin
        return;
    end
    if (window_hit(dmw0, va, plv)) begin
        pa  = {dmw0[27:25], va[28:0]};
        mat = dmw0[5:4];
        return;
    end
    if (window_hit(dmw1, va, plv)) begin
        pa  = {dmw1[27:25], va[28:0]};
        mat = dmw1[5:4];
        return;
    end
    for (int i = 0; i < ENTRIES; i++) begin
        if (m_e[i] && (m_g[i] || m_asid[i] == asid) &&
            (m_huge[i] ? va[31:22] == m_vppn[i][18:9] : va[31:13] == m_vppn[i])) begin
            k = i;
        end
    end
    if (k < 0) begin
        ecode = mmu_arch_pkg::ECODE_TLBR;
        return;
    end
    odd = m_huge[k] ? va[22] : va[12];
    pa  = m_huge[k] ? {m_ppn[k][odd][19:10], va[21:0]} : {m_ppn[k][odd], va[11:0]};
    mat = m_mat[k][odd];
    if (!m_v[k][odd]) begin
        if (acc == mmu_arch_pkg::ACC_FETCH) begin
            ecode = mmu_arch_pkg::ECODE_PIF;
        end else if (acc == mmu_arch_pkg::ACC_LOAD) begin
            ecode = mmu_arch_pkg::ECODE_PIL;
        end else begin
            ecode = mmu_arch_pkg::ECODE_PIS;
        end
    end else if (plv > m_plv[k][odd]) begin
        ecode = mmu_arch_pkg::ECODE_PPI;
    end else if (acc == mmu_arch_pkg::ACC_STORE && !m_d[k][odd]) begin
        ecode = mmu_arch_pkg::ECODE_PME;
    end
endfunction

`endif

// ==== verification/mmu_tb.sv ====
module mmu_tb;

    localparam int ENTRIES   = 16;
    localparam int IDX_W     = $clog2(ENTRIES);
    localparam int DA_OPS    = 40;
    localparam int DMW_OPS   = 60;
    localparam int TLB_OPS   = 600;
    localparam int TOTAL_OPS = DA_OPS + DMW_OPS + TLB_OPS;
    localparam int CLK_HALF  = 50;

    logic                    clk = 1'b0;
    logic                    rst_i;
    logic                    flush_i;
    logic                    lookup_valid_i;
    mmu_tlb_pkg::vaddr_t     va_i;
    mmu_arch_pkg::acc_t      acc_i;
    logic [31:0]             crmd_i;
    logic [31:0]             dmw0_i;
    logic [31:0]             dmw1_i;
    mmu_tlb_pkg::asid_t      asid_i;
    logic                    result_valid_o;
    mmu_tlb_pkg::paddr_t     pa_o;
    mmu_arch_pkg::mat_t      mat_o;
    logic                    ok_o;
    mmu_arch_pkg::ecode_t    ecode_o;
    logic                    maint_valid_i;
    mmu_arch_pkg::maint_op_t maint_op_i;
    logic [IDX_W-1:0]        maint_index_i;
    mmu_tlb_pkg::asid_t      maint_asid_i;
    logic                    entry_e_i;
    logic                    entry_g_i;
    logic                    entry_huge_i;
    mmu_tlb_pkg::vppn_t      entry_vppn_i;
    mmu_tlb_pkg::asid_t      entry_asid_i;
    mmu_tlb_pkg::ppn_t       entry_ppn0_i;
    mmu_arch_pkg::plv_t      entry_plv0_i;
    mmu_arch_pkg::mat_t      entry_mat0_i;
    logic                    entry_v0_i;
    logic                    entry_d0_i;
    mmu_tlb_pkg::ppn_t       entry_ppn1_i;
    mmu_arch_pkg::plv_t      entry_plv1_i;
    mmu_arch_pkg::mat_t      entry_mat1_i;
    logic                    entry_v1_i;
    logic                    entry_d1_i;
    logic                    maint_busy_o;
    logic                    maint_done_o;

    logic [31:0] rng_state = 32'hb0fe757d;

    `include "mmu_model.svh"

    mmu_top #(.TLB_ENTRY_NUM(ENTRIES)) i_mmu_top (.*);

    always #CLK_HALF clk = ~clk;

    function automatic logic [31:0] next_rand();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    // translated mode, windows and tlb active
    function automatic logic [31:0] paged_crmd();
        logic [31:0] c;
        c    = next_rand();
        c[3] = 1'b0;
        c[4] = 1'b1;
        return c;
    endfunction

    task automatic report_failure(input string what);
        $display("%s", what);
        $display("Checks failed");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] want);
        assert (got == want) else begin
            report_failure($sformatf("Fail at time %0t: %s is %0h, expected %0h",
                                     $time, name, got, want));
        end
    endtask

    task automatic run_lookup(input logic [31:0] va, input logic [1:0] acc,
                              input logic [31:0] crmd, input logic [31:0] dmw0,
                              input logic [31:0] dmw1, input logic [9:0] asid,
                              input logic flush);
        logic [31:0] exp_pa;
        logic [1:0]  exp_mat;
        logic [5:0]  exp_ecode;
        expect_translation(va, acc, crmd, dmw0, dmw1, asid, exp_pa, exp_mat, exp_ecode);
        lookup_valid_i = 1'b1;
        flush_i        = flush;
        va_i           = va;
        acc_i          = mmu_arch_pkg::acc_t'(acc);
        crmd_i         = crmd;
        dmw0_i         = dmw0;
        dmw1_i         = dmw1;
        asid_i         = asid;
        @(negedge clk);
        lookup_valid_i = 1'b0;  // a following lookup raises it again at once
        flush_i        = 1'b0;
        check_value("result_valid_o", result_valid_o, !flush);
        if (!flush) begin
            check_value("ecode_o", ecode_o, exp_ecode);
            check_value("ok_o", ok_o, exp_ecode == mmu_arch_pkg::ECODE_NONE);
            if (exp_ecode == mmu_arch_pkg::ECODE_NONE) begin
                check_value("pa_o", pa_o, exp_pa);
                check_value("mat_o", mat_o, exp_mat);
            end
        end
    endtask

    task automatic drive_random_entry(input int idx);
        logic [31:0] r;
        r            = next_rand();
        entry_e_i    = r[6:4] != 3'd0;
        entry_g_i    = r[8:7] == 2'd0;
        entry_huge_i = r[10:9] == 2'd0;
        entry_asid_i = 10'(r[12:11]);  // few asids, so lookups often agree
        r            = next_rand();
        entry_vppn_i = {r[18:14], 4'(idx), r[9:0]};  // index in va[26:23] keeps keys apart
        r            = next_rand();
        entry_ppn0_i = r[19:0];
        entry_plv0_i = r[21:20];
        entry_mat0_i = r[23:22];
        entry_v0_i   = r[26:24] != 3'd0;
        entry_d0_i   = r[27];
        r            = next_rand();
        entry_ppn1_i = r[19:0];
        entry_plv1_i = r[21:20];
        entry_mat1_i = r[23:22];
        entry_v1_i   = r[26:24] != 3'd0;
        entry_d1_i   = r[27];
    endtask

    task automatic run_write(input logic fill);
        int idx;
        idx = fill ? fill_ptr : int'(next_rand() % ENTRIES);
        drive_random_entry(idx);
        maint_op_i    = fill ? mmu_arch_pkg::OP_FILL : mmu_arch_pkg::OP_WRITE;
        maint_index_i = fill ? IDX_W'(next_rand()) : IDX_W'(idx);  // fill ignores it
        maint_valid_i = 1'b1;
        @(negedge clk);
        maint_valid_i = 1'b0;
        shadow_store(idx);
        if (fill) begin
            fill_ptr = (fill_ptr + 1) % ENTRIES;
        end
        check_value("maint_done_o", maint_done_o, 1);
        @(negedge clk);
        check_value("maint_done_o", maint_done_o, 0);
    endtask

    task automatic run_invalidate(input logic asid_only, input logic [9:0] asid);
        int busy_cycles;
        busy_cycles   = 0;
        maint_op_i    = asid_only ? mmu_arch_pkg::OP_INV_ASID : mmu_arch_pkg::OP_INV_ALL;
        maint_asid_i  = asid;
        maint_valid_i = 1'b1;
        @(negedge clk);
        maint_valid_i = 1'b0;
        while (maint_busy_o && busy_cycles <= ENTRIES) begin
            busy_cycles++;
            @(negedge clk);
        end
        check_value("maint_busy_o cycles", busy_cycles, ENTRIES);
        check_value("maint_done_o", maint_done_o, 1);
        shadow_invalidate(asid_only, asid);
        @(negedge clk);
        check_value("maint_done_o", maint_done_o, 0);
    endtask

    initial begin
        #((TOTAL_OPS * (ENTRIES + 3) + 10) * 2 * CLK_HALF);
        report_failure("watchdog timeout, the run did not finish in time");
    end

    initial begin
        logic [31:0] r;
        logic [31:0] va;
        logic [31:0] crmd;
        logic [31:0] dmw0;
        logic [31:0] dmw1;
        int          k;
        rst_i          = 1'b1;
        flush_i        = 1'b0;
        lookup_valid_i = 1'b0;
        va_i           = '0;
        acc_i          = mmu_arch_pkg::ACC_FETCH;
        crmd_i         = '0;
        dmw0_i         = '0;
        dmw1_i         = '0;
        asid_i         = '0;
        maint_valid_i  = 1'b0;
        maint_op_i     = mmu_arch_pkg::OP_WRITE;
        maint_index_i  = '0;
        maint_asid_i   = '0;
        drive_random_entry(0);
        shadow_clear();
        repeat (2) @(negedge clk);
        rst_i = 1'b0;
        check_value("result_valid_o", result_valid_o, 0);
        check_value("maint_busy_o", maint_busy_o, 0);
        check_value("maint_done_o", maint_done_o, 0);

        // direct address mode
        repeat (DA_OPS) begin
            crmd    = next_rand();
            crmd[3] = 1'b1;
            r       = next_rand();
            run_lookup(next_rand(), 2'(r[1:0] % 3), crmd, next_rand(), next_rand(),
                       r[11:2], 1'b0);
        end

        // direct map windows, tlb still empty
        repeat (DMW_OPS) begin
            crmd = paged_crmd();
            dmw0 = next_rand();
            r    = next_rand();
            va   = next_rand();
            dmw1 = next_rand();
            dmw1[31:29] = r[31:29];  // window 1 segment
            if (r[2]) begin
                va[31:29] = r[3] ? dmw0[31:29] : r[31:29];
            end
            run_lookup(va, 2'(r[1:0] % 3), crmd, dmw0, dmw1, r[13:4], 1'b0);
        end

        // mixed tlb maintenance and lookups, windows disabled
        repeat (TLB_OPS) begin
            r = next_rand();
            if (r[3:0] < 4'd2) begin
                run_write(1'b0);
            end else if (r[3:0] < 4'd4) begin
                run_write(1'b1);
            end else if (r[3:0] == 4'd4 && r[9:8] == 2'd0) begin
                run_invalidate(r[10], 10'(r[12:11]));
            end else begin
                k  = int'(r[7:4]);
                va = next_rand();
                if (r[9:8] != 2'd0) begin  // aim at entry k
                    va = m_huge[k] ? {m_vppn[k][18:10], va[22:0]} : {m_vppn[k], va[12:0]};
                end
                run_lookup(va, 2'(r[21:20] % 3), paged_crmd(), next_rand() & ~32'h9,
                           next_rand() & ~32'h9, r[22] ? 10'(r[24:23]) : m_asid[k],
                           r[28:25] == 4'd0);
            end
        end

        $display("All checks passed");
        $finish;
    end

endmodule

// ==== src/mmu_top.sv ====
module mmu_top #(
    parameter int TLB_ENTRY_NUM = 16,
    localparam int IDX_W = $clog2(TLB_ENTRY_NUM)
) (
    input  logic                    clk,
    input  logic                    rst_i,
    input  logic                    flush_i,
    // lookup
    input  logic                    lookup_valid_i,
    input  mmu_tlb_pkg::vaddr_t     va_i,
    input  mmu_arch_pkg::acc_t      acc_i,
    input  logic [31:0]             crmd_i,
    input  logic [31:0]             dmw0_i,
    input  logic [31:0]             dmw1_i,
    input  mmu_tlb_pkg::asid_t      asid_i,
    output logic                    result_valid_o,
    output mmu_tlb_pkg::paddr_t     pa_o,
    output mmu_arch_pkg::mat_t      mat_o,
    output logic                    ok_o,
    output mmu_arch_pkg::ecode_t    ecode_o,
    // maintenance
    input  logic                    maint_valid_i,
    input  mmu_arch_pkg::maint_op_t maint_op_i,
    input  logic [IDX_W-1:0]        maint_index_i,
    input  mmu_tlb_pkg::asid_t      maint_asid_i,
    input  logic                    entry_e_i,
    input  logic                    entry_g_i,
    input  logic                    entry_huge_i,
    input  mmu_tlb_pkg::vppn_t      entry_vppn_i,
    input  mmu_tlb_pkg::asid_t      entry_asid_i,
    input  mmu_tlb_pkg::ppn_t       entry_ppn0_i,
    input  mmu_arch_pkg::plv_t      entry_plv0_i,
    input  mmu_arch_pkg::mat_t      entry_mat0_i,
    input  logic                    entry_v0_i,
    input  logic                    entry_d0_i,
    input  mmu_tlb_pkg::ppn_t       entry_ppn1_i,
    input  mmu_arch_pkg::plv_t      entry_plv1_i,
    input  mmu_arch_pkg::mat_t      entry_mat1_i,
    input  logic                    entry_v1_i,
    input  logic                    entry_d1_i,
    output logic                    maint_busy_o,
    output logic                    maint_done_o
);

    logic               tlb_hit;
    logic               tlb_huge;
    mmu_tlb_pkg::ppn_t  tlb_ppn;
    mmu_arch_pkg::plv_t tlb_plv;
    mmu_arch_pkg::mat_t tlb_mat;
    logic               tlb_v;
    logic               tlb_d;

    logic               wr_en;
    logic               wr_clear;
    logic [IDX_W-1:0]   wr_index;
    logic               sweep_asid_only;
    mmu_tlb_pkg::asid_t sweep_asid;
    logic               fill_adv;
    logic               sweep_start;
    logic               sweep_step;
    logic [IDX_W-1:0]   fill_index;
    logic [IDX_W-1:0]   sweep_index;
    logic               sweep_last;

    tlb_array #(.TLB_ENTRY_NUM(TLB_ENTRY_NUM)) i_tlb_array (
        .clk, .rst_i, .va_i, .asid_i,
        .wr_en_i(wr_en), .wr_clear_i(wr_clear), .wr_index_i(wr_index),
        .sweep_asid_only_i(sweep_asid_only), .sweep_asid_i(sweep_asid),
        .entry_e_i, .entry_g_i, .entry_huge_i, .entry_vppn_i, .entry_asid_i,
        .entry_ppn0_i, .entry_plv0_i, .entry_mat0_i, .entry_v0_i, .entry_d0_i,
        .entry_ppn1_i, .entry_plv1_i, .entry_mat1_i, .entry_v1_i, .entry_d1_i,
        .hit_o(tlb_hit), .huge_o(tlb_huge), .ppn_o(tlb_ppn), .plv_o(tlb_plv),
        .mat_o(tlb_mat), .v_o(tlb_v), .d_o(tlb_d)
    );

    addr_translate i_addr_translate (
        .clk, .rst_i, .flush_i, .lookup_valid_i, .va_i, .acc_i,
        .crmd_i, .dmw0_i, .dmw1_i,
        .tlb_hit_i(tlb_hit), .tlb_huge_i(tlb_huge), .tlb_ppn_i(tlb_ppn),
        .tlb_plv_i(tlb_plv), .tlb_mat_i(tlb_mat), .tlb_v_i(tlb_v), .tlb_d_i(tlb_d),
        .result_valid_o, .pa_o, .mat_o, .ok_o, .ecode_o
    );

    tlb_maint_fsm #(.TLB_ENTRY_NUM(TLB_ENTRY_NUM)) i_tlb_maint_fsm (
        .clk, .rst_i, .maint_valid_i, .maint_op_i, .maint_index_i, .maint_asid_i,
        .fill_index_i(fill_index), .sweep_index_i(sweep_index),
        .sweep_last_i(sweep_last),
        .wr_en_o(wr_en), .wr_clear_o(wr_clear), .wr_index_o(wr_index),
        .sweep_asid_only_o(sweep_asid_only), .sweep_asid_o(sweep_asid),
        .fill_adv_o(fill_adv), .sweep_start_o(sweep_start), .sweep_step_o(sweep_step),
        .busy_o(maint_busy_o), .done_o(maint_done_o)
    );

    tlb_index_counter #(.TLB_ENTRY_NUM(TLB_ENTRY_NUM)) i_tlb_index_counter (
        .clk, .rst_i,
        .fill_adv_i(fill_adv), .sweep_start_i(sweep_start), .sweep_step_i(sweep_step),
        .fill_index_o(fill_index), .sweep_index_o(sweep_index),
        .sweep_last_o(sweep_last)
    );

endmodule

// ==== src/tlb_index_counter.sv ====
module tlb_index_counter #(
    parameter int TLB_ENTRY_NUM = 16,
    localparam int IDX_W = $clog2(TLB_ENTRY_NUM)
) (
    input  logic             clk,
    input  logic             rst_i,
    input  logic             fill_adv_i,
    input  logic             sweep_start_i,
    input  logic             sweep_step_i,
    output logic [IDX_W-1:0] fill_index_o,
    output logic [IDX_W-1:0] sweep_index_o,
    output logic             sweep_last_o
);

    always_ff @(posedge clk) begin
        if (rst_i) begin
            fill_index_o  <= '0;
            sweep_index_o <= '0;
        end else begin
            if (fill_adv_i) begin
                fill_index_o <= fill_index_o + 1'b1;  // wraps, entry count is a power of two
            end
            if (sweep_start_i) begin
                sweep_index_o <= '0;
            end else if (sweep_step_i) begin
                sweep_index_o <= sweep_index_o + 1'b1;
            end
        end
    end

    assign sweep_last_o = sweep_index_o == IDX_W'(TLB_ENTRY_NUM - 1);

endmodule

// ==== src/tlb_maint_fsm.sv ====
module tlb_maint_fsm #(
    parameter int TLB_ENTRY_NUM = 16,
    localparam int IDX_W = $clog2(TLB_ENTRY_NUM)
) (
    input  logic                    clk,
    input  logic                    rst_i,
    input  logic                    maint_valid_i,
    input  mmu_arch_pkg::maint_op_t maint_op_i,
    input  logic [IDX_W-1:0]        maint_index_i,
    input  mmu_tlb_pkg::asid_t      maint_asid_i,
    input  logic [IDX_W-1:0]        fill_index_i,
    input  logic [IDX_W-1:0]        sweep_index_i,
    input  logic                    sweep_last_i,
    output logic                    wr_en_o,
    output logic                    wr_clear_o,
    output logic [IDX_W-1:0]        wr_index_o,
    output logic                    sweep_asid_only_o,
    output mmu_tlb_pkg::asid_t      sweep_asid_o,
    output logic                    fill_adv_o,
    output logic                    sweep_start_o,
    output logic                    sweep_step_o,
    output logic                    busy_o,
    output logic                    done_o
);

    typedef enum logic [1:0] {IDLE, SWEEP, DONE} state_t;

    state_t                  state_q;
    state_t                  state_d;
    mmu_arch_pkg::maint_op_t op_q;

    always_ff @(posedge clk) begin
        if (rst_i) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // sweep parameters held for the whole pass
    always_ff @(posedge clk) begin
        if (sweep_start_o) begin
            op_q         <= maint_op_i;
            sweep_asid_o <= maint_asid_i;
        end
    end

    always_comb begin
        state_d       = state_q;
        wr_en_o       = 1'b0;
        wr_clear_o    = 1'b0;
        wr_index_o    = maint_index_i;
        fill_adv_o    = 1'b0;
        sweep_start_o = 1'b0;
        sweep_step_o  = 1'b0;
        case (state_q)
            IDLE: begin
                if (maint_valid_i) begin  // only idle takes new requests
                    case (maint_op_i)
                        mmu_arch_pkg::OP_WRITE: begin
                            wr_en_o = 1'b1;
                            state_d = DONE;
                        end
                        mmu_arch_pkg::OP_FILL: begin
                            wr_en_o    = 1'b1;
                            wr_index_o = fill_index_i;
                            fill_adv_o = 1'b1;
                            state_d    = DONE;
                        end
                        default: begin
                            sweep_start_o = 1'b1;
                            state_d       = SWEEP;
                        end
                    endcase
                end
            end
            SWEEP: begin
                wr_en_o      = 1'b1;
                wr_clear_o   = 1'b1;
                wr_index_o   = sweep_index_i;  // one entry per cycle
                sweep_step_o = 1'b1;
                if (sweep_last_i) begin
                    state_d = DONE;
                end
            end
            default: state_d = IDLE;
        endcase
    end

    assign sweep_asid_only_o = op_q == mmu_arch_pkg::OP_INV_ASID;
    assign busy_o            = state_q == SWEEP;
    assign done_o            = state_q == DONE;

    a_sweep_from_zero: assert property (@(posedge clk) disable iff (rst_i)
        sweep_start_o |=> sweep_index_i == '0);

endmodule

// ==== src/addr_translate.sv ====
module addr_translate (
    input  logic                    clk,
    input  logic                    rst_i,
    input  logic                    flush_i,
    input  logic                    lookup_valid_i,
    input  mmu_tlb_pkg::vaddr_t     va_i,
    input  mmu_arch_pkg::acc_t      acc_i,
    input  logic [31:0]             crmd_i,
    input  logic [31:0]             dmw0_i,
    input  logic [31:0]             dmw1_i,
    input  logic                    tlb_hit_i,
    input  logic                    tlb_huge_i,
    input  mmu_tlb_pkg::ppn_t       tlb_ppn_i,
    input  mmu_arch_pkg::plv_t      tlb_plv_i,
    input  mmu_arch_pkg::mat_t      tlb_mat_i,
    input  logic                    tlb_v_i,
    input  logic                    tlb_d_i,
    output logic                    result_valid_o,
    output mmu_tlb_pkg::paddr_t     pa_o,
    output mmu_arch_pkg::mat_t      mat_o,
    output logic                    ok_o,
    output mmu_arch_pkg::ecode_t    ecode_o
);

    mmu_arch_pkg::plv_t   plv;
    logic                 da_mode;
    logic                 dmw0_hit;
    logic                 dmw1_hit;
    logic [31:0]          dmw_sel;
    mmu_tlb_pkg::paddr_t  pa_d;
    mmu_arch_pkg::mat_t   mat_d;
    mmu_arch_pkg::ecode_t ecode_d;

    assign plv = crmd_i[mmu_arch_pkg::CRMD_PLV_LO +: 2];

    // pg clear is treated as direct too
    assign da_mode = crmd_i[mmu_arch_pkg::CRMD_DA] || !crmd_i[mmu_arch_pkg::CRMD_PG];

    assign dmw0_hit = dmw0_i[mmu_arch_pkg::DMW_VSEG_LO +: 3] == va_i[31:29] &&
                      ((plv == 2'd0 && dmw0_i[mmu_arch_pkg::DMW_PLV0]) ||
                       (plv == 2'd3 && dmw0_i[mmu_arch_pkg::DMW_PLV3]));
    assign dmw1_hit = dmw1_i[mmu_arch_pkg::DMW_VSEG_LO +: 3] == va_i[31:29] &&
                      ((plv == 2'd0 && dmw1_i[mmu_arch_pkg::DMW_PLV0]) ||
                       (plv == 2'd3 && dmw1_i[mmu_arch_pkg::DMW_PLV3]));
    assign dmw_sel  = dmw0_hit ? dmw0_i : dmw1_i;  // window 0 wins

    always_comb begin
        ecode_d = mmu_arch_pkg::ECODE_NONE;
        if (da_mode) begin
            pa_d  = va_i;
            mat_d = (acc_i == mmu_arch_pkg::ACC_FETCH) ?
                    crmd_i[mmu_arch_pkg::CRMD_DATF_LO +: 2] :
                    crmd_i[mmu_arch_pkg::CRMD_DATM_LO +: 2];
        end else if (dmw0_hit || dmw1_hit) begin
            pa_d  = {dmw_sel[mmu_arch_pkg::DMW_PSEG_LO +: 3], va_i[28:0]};
            mat_d = dmw_sel[mmu_arch_pkg::DMW_MAT_LO +: 2];
        end else begin
            pa_d  = tlb_huge_i ? {tlb_ppn_i[19:10], va_i[21:0]} : {tlb_ppn_i, va_i[11:0]};
            mat_d = tlb_mat_i;
            if (!tlb_hit_i) begin
                ecode_d = mmu_arch_pkg::ECODE_TLBR;
            end else if (!tlb_v_i) begin
                case (acc_i)
                    mmu_arch_pkg::ACC_FETCH: ecode_d = mmu_arch_pkg::ECODE_PIF;
                    mmu_arch_pkg::ACC_LOAD:  ecode_d = mmu_arch_pkg::ECODE_PIL;
                    default:                 ecode_d = mmu_arch_pkg::ECODE_PIS;
                endcase
            end else if (plv > tlb_plv_i) begin
                ecode_d = mmu_arch_pkg::ECODE_PPI;
            end else if (acc_i == mmu_arch_pkg::ACC_STORE && !tlb_d_i) begin
                ecode_d = mmu_arch_pkg::ECODE_PME;  // first store to clean page
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst_i || flush_i) begin
            result_valid_o <= 1'b0;
        end else begin
            result_valid_o <= lookup_valid_i;
        end
    end

    always_ff @(posedge clk) begin
        if (lookup_valid_i) begin
            pa_o    <= pa_d;
            mat_o   <= mat_d;
            ecode_o <= ecode_d;
            ok_o    <= ecode_d == mmu_arch_pkg::ECODE_NONE;
        end
    end

    a_acc_defined: assert property (@(posedge clk) disable iff (rst_i)
        lookup_valid_i |-> 2'(acc_i) != 2'b11);

endmodule

// ==== src/tlb_array.sv ====
module tlb_array #(
    parameter int TLB_ENTRY_NUM = 16,
    localparam int IDX_W = $clog2(TLB_ENTRY_NUM)
) (
    input  logic                 clk,
    input  logic                 rst_i,
    input  mmu_tlb_pkg::vaddr_t  va_i,
    input  mmu_tlb_pkg::asid_t   asid_i,
    input  logic                 wr_en_i,
    input  logic                 wr_clear_i,
    input  logic [IDX_W-1:0]     wr_index_i,
    input  logic                 sweep_asid_only_i,
    input  mmu_tlb_pkg::asid_t   sweep_asid_i,
    input  logic                 entry_e_i,
    input  logic                 entry_g_i,
    input  logic                 entry_huge_i,
    input  mmu_tlb_pkg::vppn_t   entry_vppn_i,
    input  mmu_tlb_pkg::asid_t   entry_asid_i,
    input  mmu_tlb_pkg::ppn_t    entry_ppn0_i,
    input  mmu_arch_pkg::plv_t   entry_plv0_i,
    input  mmu_arch_pkg::mat_t   entry_mat0_i,
    input  logic                 entry_v0_i,
    input  logic                 entry_d0_i,
    input  mmu_tlb_pkg::ppn_t    entry_ppn1_i,
    input  mmu_arch_pkg::plv_t   entry_plv1_i,
    input  mmu_arch_pkg::mat_t   entry_mat1_i,
    input  logic                 entry_v1_i,
    input  logic                 entry_d1_i,
    output logic                 hit_o,
    output logic                 huge_o,
    output mmu_tlb_pkg::ppn_t    ppn_o,
    output mmu_arch_pkg::plv_t   plv_o,
    output mmu_arch_pkg::mat_t   mat_o,
    output logic                 v_o,
    output logic                 d_o
);

    // key part
    logic [TLB_ENTRY_NUM-1:0] e_q;
    logic [TLB_ENTRY_NUM-1:0] g_q;
    logic [TLB_ENTRY_NUM-1:0] huge_q;
    mmu_tlb_pkg::vppn_t       vppn_q [TLB_ENTRY_NUM];
    mmu_tlb_pkg::asid_t       asid_q [TLB_ENTRY_NUM];

    // page part, [0] even and [1] odd
    mmu_tlb_pkg::ppn_t  ppn_q [TLB_ENTRY_NUM][2];
    mmu_arch_pkg::plv_t plv_q [TLB_ENTRY_NUM][2];
    mmu_arch_pkg::mat_t mat_q [TLB_ENTRY_NUM][2];
    logic               v_q   [TLB_ENTRY_NUM][2];
    logic               d_q   [TLB_ENTRY_NUM][2];

    logic [TLB_ENTRY_NUM-1:0] match;
    logic [TLB_ENTRY_NUM-1:0] odd;
    logic                     clear_ok;

    // asid filtered clear spares global entries and other asids
    assign clear_ok = !sweep_asid_only_i ||
                      (!g_q[wr_index_i] && asid_q[wr_index_i] == sweep_asid_i);

    always_ff @(posedge clk) begin
        if (rst_i) begin
            e_q <= '0;
        end else if (wr_en_i) begin
            if (!wr_clear_i) begin
                e_q[wr_index_i] <= entry_e_i;
            end else if (clear_ok) begin
                e_q[wr_index_i] <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en_i && !wr_clear_i) begin
            g_q[wr_index_i]       <= entry_g_i;
            huge_q[wr_index_i]    <= entry_huge_i;
            vppn_q[wr_index_i]    <= entry_vppn_i;
            asid_q[wr_index_i]    <= entry_asid_i;
            ppn_q[wr_index_i][0]  <= entry_ppn0_i;
            plv_q[wr_index_i][0]  <= entry_plv0_i;
            mat_q[wr_index_i][0]  <= entry_mat0_i;
            v_q[wr_index_i][0]    <= entry_v0_i;
            d_q[wr_index_i][0]    <= entry_d0_i;
            ppn_q[wr_index_i][1]  <= entry_ppn1_i;
            plv_q[wr_index_i][1]  <= entry_plv1_i;
            mat_q[wr_index_i][1]  <= entry_mat1_i;
            v_q[wr_index_i][1]    <= entry_v1_i;
            d_q[wr_index_i][1]    <= entry_d1_i;
        end
    end

    always_comb begin
        for (int i = 0; i < TLB_ENTRY_NUM; i++) begin
            match[i] = e_q[i] && (g_q[i] || asid_q[i] == asid_i) &&
                       (huge_q[i] ? va_i[31:22] == vppn_q[i][18:9]
                                  : va_i[31:13] == vppn_q[i]);
            odd[i]   = huge_q[i] ? va_i[22] : va_i[12];
        end
    end

    // parallel select, match is one-hot or empty
    always_comb begin
        hit_o  = 1'b0;
        huge_o = 1'b0;
        ppn_o  = '0;
        plv_o  = '0;
        mat_o  = '0;
        v_o    = 1'b0;
        d_o    = 1'b0;
        for (int i = 0; i < TLB_ENTRY_NUM; i++) begin
            if (match[i]) begin
                hit_o  = 1'b1;
                huge_o = huge_q[i];
                ppn_o  = ppn_q[i][odd[i]];
                plv_o  = plv_q[i][odd[i]];
                mat_o  = mat_q[i][odd[i]];
                v_o    = v_q[i][odd[i]];
                d_o    = d_q[i][odd[i]];
            end
        end
    end

    a_single_match: assert property (@(posedge clk) disable iff (rst_i) $onehot0(match));

endmodule

// ==== src/mmu_tlb_pkg.sv ====
package mmu_tlb_pkg;

    parameter int VA_W   = 32;
    parameter int PA_W   = 32;
    parameter int VPPN_W = 19;  // va[31:13], covers an even/odd pair
    parameter int ASID_W = 10;
    parameter int PPN_W  = 20;  // pa[31:12]

    typedef logic [VA_W-1:0]   vaddr_t;
    typedef logic [PA_W-1:0]   paddr_t;
    typedef logic [VPPN_W-1:0] vppn_t;
    typedef logic [ASID_W-1:0] asid_t;
    typedef logic [PPN_W-1:0]  ppn_t;

endpackage

// ==== src/mmu_arch_pkg.sv ====
package mmu_arch_pkg;

    typedef logic [1:0] plv_t;
    typedef logic [1:0] mat_t;
    typedef logic [5:0] ecode_t;

    typedef enum logic [1:0] {ACC_FETCH, ACC_LOAD, ACC_STORE} acc_t;
    typedef enum logic [1:0] {OP_WRITE, OP_FILL, OP_INV_ALL, OP_INV_ASID} maint_op_t;

    parameter ecode_t ECODE_NONE = 6'h00;
    parameter ecode_t ECODE_PIL  = 6'h01;  // load on invalid page
    parameter ecode_t ECODE_PIS  = 6'h02;  // store on invalid page
    parameter ecode_t ECODE_PIF  = 6'h03;  // fetch on invalid page
    parameter ecode_t ECODE_PME  = 6'h04;  // store to clean page
    parameter ecode_t ECODE_PPI  = 6'h07;
    parameter ecode_t ECODE_TLBR = 6'h3f;  // refill, no matching entry

    // crmd fields
    parameter int CRMD_PLV_LO  = 0;  // 2 bits
    parameter int CRMD_DA      = 3;
    parameter int CRMD_PG      = 4;
    parameter int CRMD_DATF_LO = 5;  // 2 bits
    parameter int CRMD_DATM_LO = 7;  // 2 bits

    // dmw fields
    parameter int DMW_PLV0    = 0;
    parameter int DMW_PLV3    = 3;
    parameter int DMW_MAT_LO  = 4;   // 2 bits
    parameter int DMW_PSEG_LO = 25;  // 3 bits
    parameter int DMW_VSEG_LO = 29;  // 3 bits

endpackage
